//--- Makefile
VERILATOR := verilator
VFLAGS := --binary --assert --timescale 1ns/1ps -j 0
TOP := tb_watch
FILE_LIST := verilog.f
BUILD_DIR := obj_dir
SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILE_LIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- display_encoder.sv
module display_encoder (
	input logic clk,
	input logic reset,
	input logic [watch_pkg::MODE_W-1:0] mode,
	input logic [watch_pkg::FIELD_W-1:0] hours,
	input logic [watch_pkg::FIELD_W-1:0] mins,
	input logic [watch_pkg::FIELD_W-1:0] secs,
	input logic [watch_pkg::FIELD_W-1:0] sw_mins,
	input logic [watch_pkg::FIELD_W-1:0] sw_secs,
	input logic [watch_pkg::HUND_W-1:0] sw_hund,
	output logic [watch_pkg::SEG_W-1:0] hex0,
	output logic [watch_pkg::SEG_W-1:0] hex1,
	output logic [watch_pkg::SEG_W-1:0] hex2,
	output logic [watch_pkg::SEG_W-1:0] hex3,
	output logic [watch_pkg::SEG_W-1:0] hex4,
	output logic [watch_pkg::SEG_W-1:0] hex5
);

	import watch_pkg::*;

	logic [HUND_W-1:0] field_hi;
	logic [HUND_W-1:0] field_mid;
	logic [HUND_W-1:0] field_lo;

	function automatic logic [DIGIT_W-1:0] tens_of(input logic [HUND_W-1:0] value);
		return DIGIT_W'(value / HUND_W'(10));
	endfunction

	function automatic logic [DIGIT_W-1:0] ones_of(input logic [HUND_W-1:0] value);
		return DIGIT_W'(value % HUND_W'(10));
	endfunction

	function automatic logic [SEG_W-1:0] seg_of(input logic [DIGIT_W-1:0] digit);
		if (digit > DIGIT_W'(9)) begin
			return SEG_BLANK;
		end
		return SEG_DIGITS[digit];
	endfunction

	always_comb begin
		if (mode == MODE_STOPWATCH) begin
			field_hi = HUND_W'(sw_mins);
			field_mid = HUND_W'(sw_secs);
			field_lo = sw_hund;
		end else begin
			field_hi = HUND_W'(hours);
			field_mid = HUND_W'(mins);
			field_lo = HUND_W'(secs);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			hex0 <= SEG_DIGITS[0];
			hex1 <= SEG_DIGITS[0];
			hex2 <= SEG_DIGITS[0];
			hex3 <= SEG_DIGITS[0];
			hex4 <= SEG_DIGITS[0];
			hex5 <= SEG_DIGITS[0];
		end else begin
			hex5 <= seg_of(tens_of(field_hi));
			hex4 <= seg_of(ones_of(field_hi));
			hex3 <= seg_of(tens_of(field_mid));
			hex2 <= seg_of(ones_of(field_mid));
			hex1 <= seg_of(tens_of(field_lo));
			hex0 <= seg_of(ones_of(field_lo));
		end
	end

endmodule

//--- key_conditioner.sv
module key_conditioner (
	input logic clk,
	input logic reset,
	input logic [watch_pkg::NUM_KEYS-1:0] keys,
	output logic [watch_pkg::NUM_KEYS-1:0] press
);

	import watch_pkg::*;

	logic [NUM_KEYS-1:0] pressed;
	logic [NUM_KEYS-1:0] stable;
	logic [NUM_KEYS-1:0] stable_d;
	logic [DEB_W-1:0] count [NUM_KEYS];

	assign pressed = ~keys; // The keys pull low when pushed.

	always_ff @(posedge clk) begin
		if (reset) begin
			stable <= '0;
			stable_d <= '0;
			for (int i = 0; i < NUM_KEYS; i++) begin
				count[i] <= '0;
			end
		end else begin
			stable_d <= stable;
			for (int i = 0; i < NUM_KEYS; i++) begin
				if (pressed[i] == stable[i]) begin
					count[i] <= '0; // Any bounce back restarts the wait.
				end else if (count[i] == DEB_W'(DEBOUNCE_CYCLES - 1)) begin
					stable[i] <= pressed[i];
					count[i] <= '0;
				end else begin
					count[i] <= count[i] + 1'b1;
				end
			end
		end
	end

	assign press = stable & ~stable_d;

	press_single_cycle: assert property (@(posedge clk) disable iff (reset)
		(press & $past(press)) == '0)
		else $error("press pulse held for more than one cycle");

endmodule

//--- mode_select.sv
module mode_select (
	input logic clk,
	input logic reset,
	input logic [watch_pkg::NUM_KEYS-1:0] press,
	output logic [watch_pkg::MODE_W-1:0] mode,
	output logic set_step,
	output logic up,
	output logic down,
	output logic sw_toggle,
	output logic sw_clear
);

	import watch_pkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= MODE_CLOCK;
			set_step <= 1'b0;
			up <= 1'b0;
			down <= 1'b0;
			sw_toggle <= 1'b0;
			sw_clear <= 1'b0;
		end else begin
			if (press[KEY_MODE]) begin
				mode <= {mode[0], mode[1]}; // Two modes, so swapping the bits toggles.
			end
			set_step <= press[KEY_SET] && (mode == MODE_CLOCK);
			up <= press[KEY_UP] && (mode == MODE_CLOCK);
			down <= press[KEY_DOWN] && (mode == MODE_CLOCK);
			sw_toggle <= press[KEY_DOWN] && (mode == MODE_STOPWATCH);
			sw_clear <= press[KEY_SET] && (mode == MODE_STOPWATCH);
		end
	end

	mode_one_hot: assert property (@(posedge clk) disable iff (reset) $onehot(mode))
		else $error("watch mode is not one-hot");

endmodule

//--- stopwatch.sv
module stopwatch (
	input logic clk,
	input logic reset,
	input logic sw_toggle,
	input logic sw_clear,
	output logic [watch_pkg::FIELD_W-1:0] sw_mins,
	output logic [watch_pkg::FIELD_W-1:0] sw_secs,
	output logic [watch_pkg::HUND_W-1:0] sw_hund
);

	import watch_pkg::*;

	logic running;
	logic [HUND_DIV_W-1:0] div;
	logic tick;

	assign tick = running && (div == HUND_DIV_W'(CYCLES_PER_HUNDREDTH - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			div <= '0;
			sw_mins <= '0;
			sw_secs <= '0;
			sw_hund <= '0;
		end else begin
			if (sw_toggle) begin
				running <= ~running;
			end

			if (sw_clear) begin
				div <= '0; // The run flag is left alone.
				sw_mins <= '0;
				sw_secs <= '0;
				sw_hund <= '0;
			end else if (running) begin
				div <= tick ? '0 : div + 1'b1;
				if (tick) begin
					sw_hund <= (sw_hund == HUND_MAX) ? '0 : sw_hund + 1'b1;
					if (sw_hund == HUND_MAX) begin
						sw_secs <= (sw_secs == SEC_MAX) ? '0 : sw_secs + 1'b1;
						if (sw_secs == SEC_MAX) begin
							sw_mins <= (sw_mins == MIN_MAX) ? '0 : sw_mins + 1'b1;
						end
					end
				end
			end
		end
	end

	hund_in_range: assert property (@(posedge clk) disable iff (reset) sw_hund <= HUND_MAX)
		else $error("stopwatch hundredths out of range");

endmodule

//--- tb_watch.sv
module tb_watch;

	timeunit 1ns;
	timeprecision 1ps;

	import watch_pkg::*;

	localparam int HOLD_CYCLES = 3 * DEBOUNCE_CYCLES;
	localparam int TIMEOUT_CYCLES = 20 * CYCLES_PER_SEC;
	localparam logic [SEG_W-1:0] SEG_TABLE [0:9] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
		7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
	}; // Active low, segment g is the top bit.

	logic clk;
	logic reset;
	logic [NUM_KEYS-1:0] keys;
	logic [SEG_W-1:0] hex0;
	logic [SEG_W-1:0] hex1;
	logic [SEG_W-1:0] hex2;
	logic [SEG_W-1:0] hex3;
	logic [SEG_W-1:0] hex4;
	logic [SEG_W-1:0] hex5;
	logic [MODE_W-1:0] leds;

	watch_top u_watch_top (
		.clk(clk), .reset(reset), .keys(keys),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5),
		.leds(leds)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic next_cycle();
		@(posedge clk);
		#1; // Inputs move and outputs are sampled just after the edge.
	endtask

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped after a failure.");
	endtask

	function automatic logic [SEG_W-1:0] digit_seg(input int digits, input int pos);
		int divisor;
		divisor = 1;
		for (int i = 0; i < pos; i++) begin
			divisor = divisor * 10;
		end
		return SEG_TABLE[DIGIT_W'((digits / divisor) % 10)];
	endfunction

	function automatic logic [6*SEG_W-1:0] display_word();
		return {hex5, hex4, hex3, hex2, hex1, hex0};
	endfunction

	function automatic logic [6*SEG_W-1:0] expected_word(input int digits);
		return {digit_seg(digits, 5), digit_seg(digits, 4), digit_seg(digits, 3),
			digit_seg(digits, 2), digit_seg(digits, 1), digit_seg(digits, 0)};
	endfunction

	task automatic check_hex(
		input string name,
		input logic [SEG_W-1:0] exp5,
		input logic [SEG_W-1:0] exp4,
		input logic [SEG_W-1:0] exp3,
		input logic [SEG_W-1:0] exp2,
		input logic [SEG_W-1:0] exp1,
		input logic [SEG_W-1:0] exp0
	);
		if ({hex5, hex4, hex3, hex2, hex1, hex0} !== {exp5, exp4, exp3, exp2, exp1, exp0}) begin
			$display("[ERROR] %s: expected %h %h %h %h %h %h, actual %h %h %h %h %h %h",
				name, exp5, exp4, exp3, exp2, exp1, exp0,
				hex5, hex4, hex3, hex2, hex1, hex0);
			abort_run();
		end
	endtask

	task automatic check_mode(input string name, input logic [MODE_W-1:0] expected);
		if (leds !== expected) begin
			$display("[ERROR] %s: expected mode %b, actual mode %b", name, expected, leds);
			abort_run();
		end
	endtask

	task automatic compare_display(input string name, input int digits);
		check_hex(name, digit_seg(digits, 5), digit_seg(digits, 4), digit_seg(digits, 3),
			digit_seg(digits, 2), digit_seg(digits, 1), digit_seg(digits, 0));
	endtask

	task automatic press_key(input int key);
		int idle;
		idle = $urandom % 8;
		repeat (idle) begin
			next_cycle();
		end
		keys = ~(NUM_KEYS'(1) << key); // Only this key pulls low.
		repeat (HOLD_CYCLES) @(posedge clk);
		#1;
		keys = '1;
		repeat (HOLD_CYCLES) @(posedge clk);
		#1;
	endtask

	task automatic expect_display(input string name, input int digits);
		int waited;
		waited = 0;
		while (display_word() != expected_word(digits) && waited < TIMEOUT_CYCLES) begin
			next_cycle();
			waited++;
		end
		compare_display(name, digits);
	endtask

	task automatic expect_leds(input string name, input logic [MODE_W-1:0] mode_value);
		int waited;
		waited = 0;
		while (leds !== mode_value && waited < TIMEOUT_CYCLES) begin
			next_cycle();
			waited++;
		end
		check_mode(name, mode_value);
	endtask

	task automatic wait_changes(input string name, input int count, input int digits);
		logic [6*SEG_W-1:0] last;
		int seen;
		int waited;
		last = display_word();
		seen = 0;
		waited = 0;
		while (seen < count) begin
			next_cycle();
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				$display("Case %s timed out waiting for the display to change.", name);
				abort_run();
			end
			if (display_word() != last) begin
				seen++;
				last = display_word();
			end
		end
		compare_display(name, digits);
	endtask

	task automatic hold_display(input string name, input int cycles);
		logic [6*SEG_W-1:0] held;
		held = display_word();
		repeat (cycles) begin
			next_cycle();
		end
		check_hex(name, held[6*SEG_W-1 -: SEG_W], held[5*SEG_W-1 -: SEG_W],
			held[4*SEG_W-1 -: SEG_W], held[3*SEG_W-1 -: SEG_W],
			held[2*SEG_W-1 -: SEG_W], held[SEG_W-1 -: SEG_W]);
	endtask

	task automatic require_fields(input int fields, input int wanted, input string line);
		if (fields != wanted) begin
			$display("A line of the case file could not be read: %s", line);
			abort_run();
		end
	endtask

	initial begin
		string line;
		string op;
		string name;
		int fd;
		int fields;
		int value;
		int digits;
		logic [MODE_W-1:0] mode_value;

		reset = 1'b1;
		keys = '1; // All keys released.
		void'($urandom(75));
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		fd = $fopen("watch_cases.txt", "r");
		if (fd == 0) begin
			$display("The case file watch_cases.txt could not be opened.");
			abort_run();
		end
		while ($fgets(line, fd) != 0) begin
			fields = $sscanf(line, "%s", op);
			if (fields != 1 || op.getc(0) == "#") begin
				continue;
			end
			case (op)
				"press": begin
					fields = $sscanf(line, "%s %d", op, value);
					require_fields(fields, 2, line);
					press_key(value);
				end
				"expect": begin
					fields = $sscanf(line, "%s %s %d", op, name, digits);
					require_fields(fields, 3, line);
					expect_display(name, digits);
				end
				"expect_mode": begin
					fields = $sscanf(line, "%s %s %b", op, name, mode_value);
					require_fields(fields, 3, line);
					expect_leds(name, mode_value);
				end
				"wait_change": begin
					fields = $sscanf(line, "%s %s %d %d", op, name, value, digits);
					require_fields(fields, 4, line);
					wait_changes(name, value, digits);
				end
				"hold_check": begin
					fields = $sscanf(line, "%s %s %d", op, name, value);
					require_fields(fields, 3, line);
					hold_display(name, value);
				end
				default: begin
					$display("The case file has an unknown operation: %s", op);
					abort_run();
				end
			endcase
		end
		$fclose(fd);
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- time_of_day.sv
module time_of_day (
	input logic clk,
	input logic reset,
	input logic set_step,
	input logic up,
	input logic down,
	output logic [watch_pkg::FIELD_W-1:0] hours,
	output logic [watch_pkg::FIELD_W-1:0] mins,
	output logic [watch_pkg::FIELD_W-1:0] secs
);

	import watch_pkg::*;

	logic [SET_W-1:0] set_field;
	logic [SEC_DIV_W-1:0] div;
	logic running;
	logic tick;

	function automatic logic [FIELD_W-1:0] adjust(
		input logic [FIELD_W-1:0] value,
		input logic [FIELD_W-1:0] limit,
		input logic inc,
		input logic dec
	);
		if (inc) begin
			return (value == limit) ? '0 : value + 1'b1;
		end
		if (dec) begin
			return (value == '0) ? limit : value - 1'b1;
		end
		return value;
	endfunction

	assign running = (set_field == SET_RUN);
	assign tick = running && (div == SEC_DIV_W'(CYCLES_PER_SEC - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			set_field <= SET_RUN;
			div <= '0;
			hours <= '0;
			mins <= '0;
			secs <= '0;
		end else begin
			if (set_step) begin
				set_field <= set_field + 1'b1; // Hours wraps back to run.
			end

			if (running) begin
				div <= tick ? '0 : div + 1'b1;
				if (tick) begin
					secs <= adjust(secs, SEC_MAX, 1'b1, 1'b0);
					if (secs == SEC_MAX) begin
						mins <= adjust(mins, MIN_MAX, 1'b1, 1'b0);
						if (mins == MIN_MAX) begin
							hours <= adjust(hours, HOUR_MAX, 1'b1, 1'b0);
						end
					end
				end
			end else begin
				div <= '0; // A fresh full second follows the return to run.
				if (set_field == SET_SECS) begin
					secs <= adjust(secs, SEC_MAX, up, down);
				end else if (set_field == SET_MINS) begin
					mins <= adjust(mins, MIN_MAX, up, down);
				end else begin
					hours <= adjust(hours, HOUR_MAX, up, down);
				end
			end
		end
	end

	fields_in_range: assert property (@(posedge clk) disable iff (reset)
		(secs <= SEC_MAX) && (mins <= MIN_MAX) && (hours <= HOUR_MAX))
		else $error("time of day field out of range");

endmodule

//--- verilog.f
watch_pkg.sv
key_conditioner.sv
mode_select.sv
time_of_day.sv
stopwatch.sv
display_encoder.sv
watch_top.sv
tb_watch.sv

//--- watch_cases.txt
# Columns: op name args; press <key>, expect <name> <hhmmss>, expect_mode <name> <bits>,
# wait_change <name> <changes> <hhmmss>, hold_check <name> <cycles>; keys 0 down 1 up 2 set 3 mode
expect reset_display 000000
expect_mode reset_mode 01
press 2
press 0
press 0
expect set_secs_wrap 000058
press 2
press 0
expect set_mins_wrap 005958
press 2
press 0
expect set_hours_wrap 235958
hold_check frozen_while_setting 120
press 2
wait_change rollover 2 000000
press 2
expect frozen_at_rollover 000000
press 3
expect_mode stopwatch_mode 10
expect stopwatch_zero 000000
press 1
expect up_ignored 000000
press 0
wait_change stopwatch_counts 1 000009
press 0
hold_check stopwatch_frozen 40
press 2
expect stopwatch_cleared 000000
press 3
expect_mode clock_mode 01
expect clock_reached 000000
press 2
press 2
press 2
wait_change clock_runs 1 000001

//--- watch_pkg.sv
package watch_pkg;

	localparam int NUM_KEYS = 4;
	localparam int KEY_DOWN = 0;
	localparam int KEY_UP = 1;
	localparam int KEY_SET = 2;
	localparam int KEY_MODE = 3;

	localparam int DEBOUNCE_CYCLES = 4;
	localparam int DEB_W = $clog2(DEBOUNCE_CYCLES);
	localparam int CYCLES_PER_SEC = 40; // Kept short so a simulated second is quick.
	localparam int SEC_DIV_W = $clog2(CYCLES_PER_SEC);
	localparam int CYCLES_PER_HUNDREDTH = 2;
	localparam int HUND_DIV_W = $clog2(CYCLES_PER_HUNDREDTH);

	localparam int FIELD_W = 6;
	localparam int HUND_W = 7;
	localparam logic [FIELD_W-1:0] SEC_MAX = 6'd59;
	localparam logic [FIELD_W-1:0] MIN_MAX = 6'd59;
	localparam logic [FIELD_W-1:0] HOUR_MAX = 6'd23;
	localparam logic [HUND_W-1:0] HUND_MAX = 7'd99;

	localparam int SET_W = 2;
	localparam logic [SET_W-1:0] SET_RUN = 2'd0;
	localparam logic [SET_W-1:0] SET_SECS = 2'd1;
	localparam logic [SET_W-1:0] SET_MINS = 2'd2;
	localparam logic [SET_W-1:0] SET_HOURS = 2'd3;

	localparam int MODE_W = 2;
	localparam logic [MODE_W-1:0] MODE_CLOCK = 2'b01;
	localparam logic [MODE_W-1:0] MODE_STOPWATCH = 2'b10;

	localparam int SEG_W = 7;
	localparam int DIGIT_W = 4;
	localparam logic [SEG_W-1:0] SEG_DIGITS [0:9] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
		7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
	}; // Active low, segment g is the top bit.
	localparam logic [SEG_W-1:0] SEG_BLANK = 7'b1111111;

endpackage

//--- watch_top.sv
module watch_top (
	input logic clk,
	input logic reset,
	input logic [watch_pkg::NUM_KEYS-1:0] keys,
	output logic [watch_pkg::SEG_W-1:0] hex0,
	output logic [watch_pkg::SEG_W-1:0] hex1,
	output logic [watch_pkg::SEG_W-1:0] hex2,
	output logic [watch_pkg::SEG_W-1:0] hex3,
	output logic [watch_pkg::SEG_W-1:0] hex4,
	output logic [watch_pkg::SEG_W-1:0] hex5,
	output logic [watch_pkg::MODE_W-1:0] leds
);

	import watch_pkg::*;

	logic [NUM_KEYS-1:0] press;
	logic [MODE_W-1:0] mode;
	logic set_step;
	logic up;
	logic down;
	logic sw_toggle;
	logic sw_clear;
	logic [FIELD_W-1:0] hours;
	logic [FIELD_W-1:0] mins;
	logic [FIELD_W-1:0] secs;
	logic [FIELD_W-1:0] sw_mins;
	logic [FIELD_W-1:0] sw_secs;
	logic [HUND_W-1:0] sw_hund;

	assign leds = mode; // One LED per mode.

	key_conditioner u_key_conditioner (.clk(clk), .reset(reset), .keys(keys), .press(press));

	mode_select u_mode_select (
		.clk(clk), .reset(reset), .press(press), .mode(mode),
		.set_step(set_step), .up(up), .down(down),
		.sw_toggle(sw_toggle), .sw_clear(sw_clear)
	);

	time_of_day u_time_of_day (
		.clk(clk), .reset(reset), .set_step(set_step), .up(up), .down(down),
		.hours(hours), .mins(mins), .secs(secs)
	);

	stopwatch u_stopwatch (
		.clk(clk), .reset(reset), .sw_toggle(sw_toggle), .sw_clear(sw_clear),
		.sw_mins(sw_mins), .sw_secs(sw_secs), .sw_hund(sw_hund)
	);

	display_encoder u_display_encoder (
		.clk(clk), .reset(reset), .mode(mode),
		.hours(hours), .mins(mins), .secs(secs),
		.sw_mins(sw_mins), .sw_secs(sw_secs), .sw_hund(sw_hund),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
	);

endmodule
